// File: src/gfx_pkg.sv
package gfx_pkg;

  // screen and pixel types
  typedef logic [9:0] coord_t;
  typedef logic [23:0] color_t;
  typedef logic [5:0] frame_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  // one line to draw, as issued by the register block
  typedef struct packed {
    point_t p0;
    point_t p1;
    color_t color;
    frame_t frame;
  } line_cmd_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    color_t color;
    frame_t frame;
  } pixel_t;

  // word address of the 8-pixel group that holds the target pixel
  typedef struct packed {
    logic [5:0] zero_hi;
    frame_t frame;
    coord_t y;
    logic [6:0] x_hi;
    logic [1:0] zero_lo;
  } mem_req_t;

  // a set mask bit keeps the byte in memory unchanged
  typedef struct packed {
    logic [127:0] data;
    logic [15:0] mask;
  } wdf_beat_t;

  // register map
  localparam int AXI_ADDR_W = 8;
  localparam logic [AXI_ADDR_W-1:0] REG_COLOR = 8'h00;
  localparam logic [AXI_ADDR_W-1:0] REG_P0 = 8'h04;
  localparam logic [AXI_ADDR_W-1:0] REG_P1 = 8'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_FRAME = 8'h0c;
  localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 8'h10;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  logic [WIDTH-1:0]  din,
  output logic              full,
  output logic [WIDTH-1:0]  dout,
  output logic              valid,
  input  logic              rd_en
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;
  logic do_wr;
  logic do_rd;

  assign full = count == DEPTH;
  assign valid = count != 0;
  // head is visible without a read strobe
  assign dout = mem[rd_ptr];
  assign do_wr = push && !full;
  assign do_rd = rd_en && valid;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/line_regs.sv
`timescale 1ns/1ns

module line_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [gfx_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
  input  logic                            s_axi_awvalid,
  output logic                            s_axi_awready,
  input  logic [31:0]                     s_axi_wdata,
  input  logic [3:0]                      s_axi_wstrb,
  input  logic                            s_axi_wvalid,
  output logic                            s_axi_wready,
  output logic [1:0]                      s_axi_bresp,
  output logic                            s_axi_bvalid,
  input  logic                            s_axi_bready,
  input  logic [gfx_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
  input  logic                            s_axi_arvalid,
  output logic                            s_axi_arready,
  output logic [31:0]                     s_axi_rdata,
  output logic [1:0]                      s_axi_rresp,
  output logic                            s_axi_rvalid,
  input  logic                            s_axi_rready,
  output gfx_pkg::line_cmd_t              cmd,
  output logic                            cmd_valid,
  input  logic                            cmd_ready,
  input  logic                            engine_active
);

  gfx_pkg::color_t color_q;
  gfx_pkg::point_t p0_q;
  gfx_pkg::point_t p1_q;
  gfx_pkg::frame_t frame_q;
  logic busy;
  logic wr_accept;
  logic rd_accept;
  logic start;
  logic [31:0] wr_word;

  function automatic logic is_mapped(input logic [gfx_pkg::AXI_ADDR_W-1:0] addr);
    return addr == gfx_pkg::REG_COLOR || addr == gfx_pkg::REG_P0 ||
           addr == gfx_pkg::REG_P1 || addr == gfx_pkg::REG_FRAME ||
           addr == gfx_pkg::REG_CTRL;
  endfunction

  // readback view of one register, zero when unmapped
  function automatic logic [31:0] reg_word(input logic [gfx_pkg::AXI_ADDR_W-1:0] addr);
    case (addr)
      gfx_pkg::REG_COLOR: return {8'h00, color_q};
      gfx_pkg::REG_P0:    return {6'd0, p0_q.x, 6'd0, p0_q.y};
      gfx_pkg::REG_P1:    return {6'd0, p1_q.x, 6'd0, p1_q.y};
      gfx_pkg::REG_FRAME: return {26'd0, frame_q};
      gfx_pkg::REG_CTRL:  return {31'd0, busy};
      default:            return 32'd0;
    endcase
  endfunction

  assign busy = cmd_valid | engine_active;

  // address and data are taken together
  assign wr_accept = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign s_axi_awready = wr_accept;
  assign s_axi_wready = wr_accept;
  assign rd_accept = s_axi_arvalid & ~s_axi_rvalid;
  assign s_axi_arready = ~s_axi_rvalid;

  // merge the strobed bytes over the current contents
  always_comb begin
    wr_word = reg_word(s_axi_awaddr);
    for (int i = 0; i < 4; i++) begin
      if (s_axi_wstrb[i]) begin
        wr_word[8*i +: 8] = s_axi_wdata[8*i +: 8];
      end
    end
  end

  assign start = wr_accept && s_axi_awaddr == gfx_pkg::REG_CTRL &&
                 s_axi_wstrb[0] && s_axi_wdata[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      color_q <= '0;
      p0_q <= '0;
      p1_q <= '0;
      frame_q <= '0;
    end else if (wr_accept) begin
      case (s_axi_awaddr)
        gfx_pkg::REG_COLOR: color_q <= wr_word[23:0];
        gfx_pkg::REG_P0:    p0_q <= '{x: wr_word[25:16], y: wr_word[9:0]};
        gfx_pkg::REG_P1:    p1_q <= '{x: wr_word[25:16], y: wr_word[9:0]};
        gfx_pkg::REG_FRAME: frame_q <= wr_word[5:0];
        default:            ;
      endcase
    end
  end

  // response handshakes
  always_ff @(posedge clk) begin
    if (rst) begin
      s_axi_bvalid <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      if (wr_accept) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
      if (rd_accept) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      s_axi_bresp <= is_mapped(s_axi_awaddr) ? gfx_pkg::RESP_OKAY : gfx_pkg::RESP_SLVERR;
    end
    if (rd_accept) begin
      s_axi_rdata <= reg_word(s_axi_araddr);
      s_axi_rresp <= is_mapped(s_axi_araddr) ? gfx_pkg::RESP_OKAY : gfx_pkg::RESP_SLVERR;
    end
  end

  // start is dropped while a line is pending or drawing
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      cmd_valid <= 1'b0;
    end else if (start && !busy) begin
      cmd_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      cmd <= '{p0: p0_q, p1: p1_q, color: color_q, frame: frame_q};
    end
  end

endmodule

// File: src/line_stepper.sv
`timescale 1ns/1ns

module line_stepper (
  input  logic                clk,
  input  logic                rst,
  input  gfx_pkg::line_cmd_t  cmd,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  output gfx_pkg::pixel_t     pix,
  output logic                pix_valid,
  input  logic                pix_ready,
  output logic                active
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_RUN
  } state_t;

  state_t state;
  gfx_pkg::line_cmd_t cmd_q;

  // setup terms, u is the major axis and v the minor one
  logic steep;
  gfx_pkg::coord_t a_u;
  gfx_pkg::coord_t a_v;
  gfx_pkg::coord_t b_u;
  gfx_pkg::coord_t b_v;
  gfx_pkg::coord_t u_start;
  gfx_pkg::coord_t v_start;
  gfx_pkg::coord_t u_stop;
  gfx_pkg::coord_t v_stop;

  // walking state
  logic steep_q;
  logic v_down_q;
  gfx_pkg::coord_t u_q;
  gfx_pkg::coord_t v_q;
  gfx_pkg::coord_t u_end_q;
  gfx_pkg::coord_t dmaj_q;
  gfx_pkg::coord_t dmin_q;
  logic signed [11:0] err_q;
  logic signed [11:0] err_dec;
  logic last;

  function automatic gfx_pkg::coord_t abs_diff(input gfx_pkg::coord_t a,
                                               input gfx_pkg::coord_t b);
    return (a > b) ? a - b : b - a;
  endfunction

  always_comb begin
    steep = abs_diff(cmd_q.p1.y, cmd_q.p0.y) > abs_diff(cmd_q.p1.x, cmd_q.p0.x);
    a_u = steep ? cmd_q.p0.y : cmd_q.p0.x;
    a_v = steep ? cmd_q.p0.x : cmd_q.p0.y;
    b_u = steep ? cmd_q.p1.y : cmd_q.p1.x;
    b_v = steep ? cmd_q.p1.x : cmd_q.p1.y;
    // walk with the major coordinate increasing
    if (a_u > b_u) begin
      u_start = b_u;
      v_start = b_v;
      u_stop = a_u;
      v_stop = a_v;
    end else begin
      u_start = a_u;
      v_start = a_v;
      u_stop = b_u;
      v_stop = b_v;
    end
  end

  assign err_dec = err_q - $signed({2'b00, dmin_q});
  assign last = u_q == u_end_q;

  assign cmd_ready = state == ST_IDLE;
  assign pix_valid = state == ST_RUN;
  assign active = state != ST_IDLE;

  // swap back to screen x and y
  assign pix = '{x: steep_q ? v_q : u_q,
                 y: steep_q ? u_q : v_q,
                 color: cmd_q.color,
                 frame: cmd_q.frame};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  if (cmd_valid) state <= ST_SETUP;
        ST_SETUP: state <= ST_RUN;
        ST_RUN:   if (pix_ready && last) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cmd_valid) begin
      cmd_q <= cmd;
    end
    if (state == ST_SETUP) begin
      steep_q <= steep;
      u_q <= u_start;
      v_q <= v_start;
      u_end_q <= u_stop;
      dmaj_q <= u_stop - u_start;
      dmin_q <= abs_diff(v_stop, v_start);
      v_down_q <= v_stop < v_start;
      err_q <= $signed({3'b000, u_stop[9:1] - u_start[9:1] - (u_stop[0] < u_start[0])});
    end else if (state == ST_RUN && pix_ready && !last) begin
      u_q <= u_q + 1'b1;
      if (err_dec < 0) begin
        v_q <= v_down_q ? v_q - 1'b1 : v_q + 1'b1;
        err_q <= err_dec + $signed({2'b00, dmaj_q});
      end else begin
        err_q <= err_dec;
      end
    end
  end

endmodule

// File: src/pixel_writer.sv
`timescale 1ns/1ns

module pixel_writer (
  input  logic                clk,
  input  logic                rst,
  input  gfx_pkg::pixel_t     pix,
  input  logic                pix_valid,
  output logic                pix_ready,
  output logic                af_push,
  output gfx_pkg::mem_req_t   af_din,
  input  logic                af_full,
  output logic                wdf_push,
  output gfx_pkg::wdf_beat_t  wdf_din,
  input  logic                wdf_full,
  output logic                active
);

  typedef enum logic {
    BEAT0,
    BEAT1
  } state_t;

  state_t state;
  logic [2:0] slot;
  logic [127:0] beat_data;

  // clear the four mask bits of the slot when the beat holds it
  function automatic logic [15:0] beat_mask(input logic [2:0] s, input logic beat);
    logic [15:0] m;
    m = 16'hffff;
    if (s[2] == beat) begin
      m[15 - 4*s[1:0] -: 4] = 4'h0;
    end
    return m;
  endfunction

  assign slot = pix.x[2:0];
  assign beat_data = {4{{8'h00, pix.color}}};

  assign af_din = '{zero_hi: '0,
                    frame: pix.frame,
                    y: pix.y,
                    x_hi: pix.x[9:3],
                    zero_lo: '0};
  assign wdf_din = '{data: beat_data, mask: beat_mask(slot, state == BEAT1)};

  // address and first beat go in together
  assign af_push = state == BEAT0 && pix_valid && !af_full && !wdf_full;
  assign pix_ready = state == BEAT1 && !wdf_full;
  assign wdf_push = af_push || pix_ready;
  assign active = state == BEAT1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BEAT0;
    end else if (af_push) begin
      state <= BEAT1;
    end else if (pix_ready) begin
      state <= BEAT0;
    end
  end

endmodule

// File: src/line_draw_top.sv
`timescale 1ns/1ns

module line_draw_top #(
  parameter int AF_DEPTH = 16,
  parameter int WDF_DEPTH = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [gfx_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
  input  logic                            s_axi_awvalid,
  output logic                            s_axi_awready,
  input  logic [31:0]                     s_axi_wdata,
  input  logic [3:0]                      s_axi_wstrb,
  input  logic                            s_axi_wvalid,
  output logic                            s_axi_wready,
  output logic [1:0]                      s_axi_bresp,
  output logic                            s_axi_bvalid,
  input  logic                            s_axi_bready,
  input  logic [gfx_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
  input  logic                            s_axi_arvalid,
  output logic                            s_axi_arready,
  output logic [31:0]                     s_axi_rdata,
  output logic [1:0]                      s_axi_rresp,
  output logic                            s_axi_rvalid,
  input  logic                            s_axi_rready,
  output gfx_pkg::mem_req_t               af_dout,
  output logic                            af_valid,
  input  logic                            af_rd_en,
  output gfx_pkg::wdf_beat_t              wdf_dout,
  output logic                            wdf_valid,
  input  logic                            wdf_rd_en
);

  gfx_pkg::line_cmd_t cmd;
  logic cmd_valid;
  logic cmd_ready;
  gfx_pkg::pixel_t pix;
  logic pix_valid;
  logic pix_ready;
  logic step_active;
  logic wr_active;
  logic engine_active;
  logic af_push;
  logic af_full;
  gfx_pkg::mem_req_t af_din;
  logic wdf_push;
  logic wdf_full;
  gfx_pkg::wdf_beat_t wdf_din;

  // busy covers the walk and the last pixel's second beat
  assign engine_active = step_active | wr_active;

  line_regs regs0 (
    .clk(clk),
    .rst(rst),
    .s_axi_awaddr(s_axi_awaddr),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata(s_axi_wdata),
    .s_axi_wstrb(s_axi_wstrb),
    .s_axi_wvalid(s_axi_wvalid),
    .s_axi_wready(s_axi_wready),
    .s_axi_bresp(s_axi_bresp),
    .s_axi_bvalid(s_axi_bvalid),
    .s_axi_bready(s_axi_bready),
    .s_axi_araddr(s_axi_araddr),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata(s_axi_rdata),
    .s_axi_rresp(s_axi_rresp),
    .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rready(s_axi_rready),
    .cmd(cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .engine_active(engine_active)
  );

  line_stepper stepper0 (
    .clk(clk),
    .rst(rst),
    .cmd(cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .pix(pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .active(step_active)
  );

  pixel_writer writer0 (
    .clk(clk),
    .rst(rst),
    .pix(pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .af_push(af_push),
    .af_din(af_din),
    .af_full(af_full),
    .wdf_push(wdf_push),
    .wdf_din(wdf_din),
    .wdf_full(wdf_full),
    .active(wr_active)
  );

  sync_fifo #(
    .WIDTH($bits(gfx_pkg::mem_req_t)),
    .DEPTH(AF_DEPTH)
  ) af_fifo0 (
    .clk(clk),
    .rst(rst),
    .push(af_push),
    .din(af_din),
    .full(af_full),
    .dout(af_dout),
    .valid(af_valid),
    .rd_en(af_rd_en)
  );

  sync_fifo #(
    .WIDTH($bits(gfx_pkg::wdf_beat_t)),
    .DEPTH(WDF_DEPTH)
  ) wdf_fifo0 (
    .clk(clk),
    .rst(rst),
    .push(wdf_push),
    .din(wdf_din),
    .full(wdf_full),
    .dout(wdf_dout),
    .valid(wdf_valid),
    .rd_en(wdf_rd_en)
  );

endmodule

// File: testbench/line_draw_assert.sv
`timescale 1ns/1ns

module line_draw_assert (
  input logic clk,
  input logic rst,
  input logic af_push,
  input logic af_full,
  input logic wdf_push,
  input logic wdf_full,
  input logic pix_ready
);

  // set by an address push, cleared when its second beat releases the pixel
  logic addr_open;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_open <= 1'b0;
    end else if (af_push) begin
      addr_open <= 1'b1;
    end else if (pix_ready) begin
      addr_open <= 1'b0;
    end
  end

  no_af_overflow: assert property (@(posedge clk) disable iff (rst) af_push |-> !af_full)
    else $error("address push into a full FIFO");

  no_wdf_overflow: assert property (@(posedge clk) disable iff (rst) wdf_push |-> !wdf_full)
    else $error("data push into a full FIFO");

  // address goes with beat 0 and never overtakes the previous pixel's beat 1
  af_with_beat: assert property (@(posedge clk) disable iff (rst)
      af_push |-> wdf_push && !addr_open)
    else $error("address push without a data beat or before the previous second beat");

  // pixel released only on beat 1 of an address already pushed
  ready_on_beat: assert property (@(posedge clk) disable iff (rst)
      pix_ready |-> wdf_push && addr_open && !af_push)
    else $error("pixel accepted without its second data beat");

  // first reset edge still sees unreset state
  quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !af_push && !wdf_push)
    else $error("FIFO push during reset");

endmodule

bind pixel_writer line_draw_assert writer_check0 (
  .clk(clk),
  .rst(rst),
  .af_push(af_push),
  .af_full(af_full),
  .wdf_push(wdf_push),
  .wdf_full(wdf_full),
  .pix_ready(pix_ready)
);

// File: testbench/tb_line_draw.sv
`timescale 1ns/1ns

module tb_line_draw;

  localparam int LIMIT = 20000;
  localparam logic [1:0] OKAY = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic clk;
  logic rst;
  logic [7:0] s_axi_awaddr;
  logic s_axi_awvalid;
  logic s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0] s_axi_wstrb;
  logic s_axi_wvalid;
  logic s_axi_wready;
  logic [1:0] s_axi_bresp;
  logic s_axi_bvalid;
  logic s_axi_bready;
  logic [7:0] s_axi_araddr;
  logic s_axi_arvalid;
  logic s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0] s_axi_rresp;
  logic s_axi_rvalid;
  logic s_axi_rready;
  gfx_pkg::mem_req_t af_dout;
  logic af_valid;
  logic af_rd_en;
  gfx_pkg::wdf_beat_t wdf_dout;
  logic wdf_valid;
  logic wdf_rd_en;

  // expected FIFO contents, in order
  logic [30:0] exp_addr[$];
  logic [143:0] exp_beat[$];
  logic [31:0] rng;
  logic [31:0] stall_rng;
  int stall_level;
  int drain_lvl;
  string test_name;
  int checks;
  int mismatches;
  int other_errors;
  logic [31:0] rd_word;
  logic [1:0] rd_resp;

  // tiny FIFOs so the writer sees back-pressure
  line_draw_top #(.AF_DEPTH(2), .WDF_DEPTH(4)) dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic int abs_i(input int a);
    return (a < 0) ? -a : a;
  endfunction

  task automatic report_and_finish(input bit timed_out);
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    if (!timed_out && mismatches == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    other_errors++;
    $display("timeout in %s while waiting for %s", test_name, what);
    report_and_finish(1'b1);
  endtask

  task automatic check_val(input string what, input logic [143:0] exp_v,
                           input logic [143:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      mismatches++;
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    s_axi_awaddr = addr;
    s_axi_wdata = data;
    s_axi_wstrb = 4'hf;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == LIMIT) fail_timeout("the write to be accepted");
    end while (!s_axi_awready);
    @(posedge clk);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == LIMIT) fail_timeout("the write response");
    end while (!s_axi_bvalid);
    resp = s_axi_bresp;
    @(posedge clk);
    #2;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    s_axi_araddr = addr;
    s_axi_arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == LIMIT) fail_timeout("the read to be accepted");
    end while (!s_axi_arready);
    @(posedge clk);
    #2;
    s_axi_arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == LIMIT) fail_timeout("the read data");
    end while (!s_axi_rvalid);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(posedge clk);
    #2;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_val("write response", OKAY, resp);
  endtask

  task automatic reg_rw(input logic [7:0] addr, input logic [31:0] wdata,
                        input logic [31:0] exp_rd);
    logic [31:0] rdata;
    logic [1:0] resp;
    write_ok(addr, wdata);
    axi_read(addr, rdata, resp);
    check_val("readback", exp_rd, rdata);
    check_val("read response", OKAY, resp);
  endtask

  // one address and two beats per pixel
  task automatic push_pixel(input logic [9:0] x, input logic [9:0] y,
                            input logic [23:0] color, input logic [5:0] frame);
    logic [15:0] hit;
    hit = ~(16'hf000 >> (4 * x[1:0]));
    exp_addr.push_back({6'd0, frame, y, x[9:3], 2'b00});
    exp_beat.push_back({{4{8'h00, color}}, x[2] ? 16'hffff : hit});
    exp_beat.push_back({{4{8'h00, color}}, x[2] ? hit : 16'hffff});
  endtask

  // reference Bresenham walk
  task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                            input logic [23:0] color, input logic [5:0] frame);
    int au;
    int av;
    int bu;
    int bv;
    int t;
    int dmaj;
    int dmin;
    int err;
    int v;
    int vstep;
    bit steep;
    steep = abs_i(y1 - y0) > abs_i(x1 - x0);
    au = steep ? y0 : x0;
    av = steep ? x0 : y0;
    bu = steep ? y1 : x1;
    bv = steep ? x1 : y1;
    if (au > bu) begin
      t = au;
      au = bu;
      bu = t;
      t = av;
      av = bv;
      bv = t;
    end
    dmaj = bu - au;
    dmin = abs_i(bv - av);
    vstep = (bv < av) ? -1 : 1;
    err = dmaj / 2;
    v = av;
    for (int u = au; u <= bu; u++) begin
      if (steep) begin
        push_pixel(v, u, color, frame);
      end else begin
        push_pixel(u, v, color, frame);
      end
      err -= dmin;
      if (err < 0) begin
        v += vstep;
        err += dmaj;
      end
    end
  endtask

  task automatic program_line(input logic [9:0] x0, input logic [9:0] y0,
                              input logic [9:0] x1, input logic [9:0] y1,
                              input logic [23:0] color, input logic [5:0] frame);
    write_ok(gfx_pkg::REG_COLOR, {8'h00, color});
    write_ok(gfx_pkg::REG_P0, {6'd0, x0, 6'd0, y0});
    write_ok(gfx_pkg::REG_P1, {6'd0, x1, 6'd0, y1});
    write_ok(gfx_pkg::REG_FRAME, {26'd0, frame});
    model_line(x0, y0, x1, y1, color, frame);
    write_ok(gfx_pkg::REG_CTRL, 32'd1);
  endtask

  // busy low, then every expected entry popped
  task automatic wait_done();
    logic [31:0] data;
    logic [1:0] resp;
    int n;
    n = 0;
    do begin
      axi_read(gfx_pkg::REG_CTRL, data, resp);
      n++;
      if (n == LIMIT) fail_timeout("busy to fall");
    end while (data[0]);
    n = 0;
    while (exp_addr.size() != 0 || exp_beat.size() != 0) begin
      if (n == LIMIT) fail_timeout("the FIFOs to drain");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic draw_line(input logic [9:0] x0, input logic [9:0] y0,
                           input logic [9:0] x1, input logic [9:0] y1,
                           input logic [23:0] color, input logic [5:0] frame);
    program_line(x0, y0, x1, y1, color, frame);
    wait_done();
  endtask

  task automatic random_line();
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] c;
    r = rand_word();
    hi = rand_word();
    c = rand_word();
    draw_line({hi[31:30], r[7:0]}, {hi[29:28], r[15:8]},
              {hi[31:30], r[23:16]}, {hi[29:28], r[31:24]}, c[23:0], c[29:24]);
  endtask

  // memory side, pops with random stalls
  always begin
    @(posedge clk);
    drain_lvl = stall_level;
    stall_rng = xorshift(stall_rng);
    #2;
    af_rd_en = stall_rng[1:0] >= drain_lvl;
    wdf_rd_en = stall_rng[9:8] >= drain_lvl;
    @(negedge clk);
    if (af_valid && af_rd_en) begin
      if (exp_addr.size() == 0) begin
        other_errors++;
        $display("unexpected address %h in %s with no pixel left", af_dout, test_name);
      end else begin
        check_val("address", exp_addr.pop_front(), af_dout);
      end
    end
    if (wdf_valid && wdf_rd_en) begin
      if (exp_beat.size() == 0) begin
        other_errors++;
        $display("unexpected data beat %h in %s with no pixel left", wdf_dout, test_name);
      end else begin
        check_val("beat", exp_beat.pop_front(), wdf_dout);
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b1;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b1;
    af_rd_en = 1'b0;
    wdf_rd_en = 1'b0;
    rng = 32'h6cb7;
    stall_rng = ~32'h6cb7;
    stall_level = 4;
    checks = 0;
    mismatches = 0;
    other_errors = 0;
    test_name = "reset";
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    stall_level = 0;

    test_name = "registers";
    reg_rw(gfx_pkg::REG_COLOR, 32'hffabcdef, 32'h00abcdef);
    reg_rw(gfx_pkg::REG_P0, 32'hffffffff, 32'h03ff03ff);
    reg_rw(gfx_pkg::REG_P1, 32'h01230045, 32'h01230045);
    reg_rw(gfx_pkg::REG_FRAME, 32'h000000ff, 32'h0000003f);
    reg_rw(gfx_pkg::REG_CTRL, 32'h00000000, 32'h00000000);
    axi_write(8'h14, 32'h12345678, rd_resp);
    check_val("unmapped write response", SLVERR, rd_resp);
    axi_read(8'h14, rd_word, rd_resp);
    check_val("unmapped read data", 32'd0, rd_word);
    check_val("unmapped read response", SLVERR, rd_resp);

    test_name = "shallow";
    draw_line(10, 20, 40, 20, 24'h123456, 6'd1);
    draw_line(300, 100, 250, 90, 24'hff8000, 6'd2);
    draw_line(1000, 900, 1023, 910, 24'h00ff00, 6'd63);

    test_name = "steep";
    draw_line(5, 5, 5, 30, 24'h0000ff, 6'd3);
    draw_line(50, 10, 40, 60, 24'habcdef, 6'd4);
    draw_line(612, 650, 600, 700, 24'h777777, 6'd5);
    draw_line(7, 7, 7, 7, 24'h010203, 6'd6);

    test_name = "stalls";
    stall_level = 3;
    repeat (3) random_line();
    stall_level = 2;
    repeat (2) random_line();

    // memory side stopped so the engine stays busy
    test_name = "busy";
    stall_level = 4;
    program_line(0, 0, 60, 0, 24'h55aa55, 6'd9);
    axi_read(gfx_pkg::REG_CTRL, rd_word, rd_resp);
    check_val("busy while drawing", 32'd1, rd_word);
    write_ok(gfx_pkg::REG_P0, {6'd0, 10'd200, 6'd0, 10'd200});
    write_ok(gfx_pkg::REG_CTRL, 32'd1);
    axi_read(gfx_pkg::REG_CTRL, rd_word, rd_resp);
    check_val("busy after dropped start", 32'd1, rd_word);
    stall_level = 1;
    wait_done();
    repeat (30) @(posedge clk);
    #2;
    check_val("no extra address", 1'b0, af_valid);

    test_name = "frames";
    repeat (5) random_line();

    repeat (30) @(posedge clk);
    #2;
    check_val("address FIFO empty at end", 1'b0, af_valid);
    check_val("data FIFO empty at end", 1'b0, wdf_valid);
    report_and_finish(1'b0);
  end

endmodule

// File: compile.f
src/gfx_pkg.sv
src/sync_fifo.sv
src/line_regs.sv
src/line_stepper.sv
src/pixel_writer.sv
src/line_draw_top.sv
testbench/line_draw_assert.sv
testbench/tb_line_draw.sv

// File: Bender.yml
package:
  name: line_draw

sources:
  - src/gfx_pkg.sv
  - src/sync_fifo.sv
  - src/line_regs.sv
  - src/line_stepper.sv
  - src/pixel_writer.sv
  - src/line_draw_top.sv
  - target: test
    files:
      - testbench/line_draw_assert.sv
      - testbench/tb_line_draw.sv
